/* Makefile */
SRCS := $(shell cat vlog.f)

all: run

obj_dir/Vtb_frontend: vlog.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_frontend -f vlog.f -o Vtb_frontend

run: obj_dir/Vtb_frontend
	./obj_dir/Vtb_frontend > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* frontend_ibuf_top.sv */
`timescale 1ns/1ps

module frontend_ibuf_top import ibuf_pkg::*; (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       redirect,
    input  logic                                       stall,
    input  logic                                       fetch_valid,
    input  logic [block_inst_size-1:0][inst_width-1:0] fetch_inst,
    input  logic [slot_idx_width-1:0]                  fetch_start,
    input  logic [block_num_width-1:0]                 fetch_num,
    input  logic [fsq_idx_width-1:0]                   fetch_fsq_idx,
    input  logic                                       fetch_iam,
    output logic                                       fetch_ready,
    output logic                                       full,
    output logic [fetch_width-1:0]                     out_en,
    output logic [fetch_width-1:0][inst_width-1:0]     out_inst,
    output logic [fetch_width-1:0][fsq_idx_width-1:0]  out_fsq_idx,
    output logic [fetch_width-1:0][slot_idx_width-1:0] out_offset,
    output logic [fetch_width-1:0]                     out_iam
);

    logic [block_inst_size-1:0]                 pd_en;
    logic [block_num_width-1:0]                 pd_num;
    logic [slot_idx_width-1:0]                  pd_shift_idx;
    logic [block_inst_size-1:0][inst_width-1:0] pd_inst;
    logic [fsq_idx_width-1:0]                   pd_fsq_idx;
    logic                                       pd_iam;

    predecode u_predecode (
        .clk           (clk),
        .rst           (rst),
        .redirect      (redirect),
        .fetch_valid   (fetch_valid),
        .fetch_inst    (fetch_inst),
        .fetch_start   (fetch_start),
        .fetch_num     (fetch_num),
        .fetch_fsq_idx (fetch_fsq_idx),
        .fetch_iam     (fetch_iam),
        .full          (full),
        .fetch_ready   (fetch_ready),
        .pd_en         (pd_en),
        .pd_num        (pd_num),
        .pd_shift_idx  (pd_shift_idx),
        .pd_inst       (pd_inst),
        .pd_fsq_idx    (pd_fsq_idx),
        .pd_iam        (pd_iam)
    );

    // full also leaves the top so the buffer occupancy can be watched from outside
    inst_buffer u_inst_buffer (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .stall        (stall),
        .pd_en        (pd_en),
        .pd_num       (pd_num),
        .pd_shift_idx (pd_shift_idx),
        .pd_inst      (pd_inst),
        .pd_fsq_idx   (pd_fsq_idx),
        .pd_iam       (pd_iam),
        .full         (full),
        .out_en       (out_en),
        .out_inst     (out_inst),
        .out_fsq_idx  (out_fsq_idx),
        .out_offset   (out_offset),
        .out_iam      (out_iam)
    );

endmodule

/* ibuf_pkg.sv */
package ibuf_pkg;

    // decode side
    localparam int fetch_width = 4;

    // fetch block shape
    localparam int block_inst_size = 8;
    localparam int inst_width      = 32;
    localparam int slot_idx_width  = $clog2(block_inst_size);
    localparam int block_num_width = $clog2(block_inst_size) + 1;  // counts 0 to 8

    // banked storage
    localparam int ibuf_bank_num   = 8;
    localparam int ibuf_bank_size  = 4;
    localparam int ibuf_size       = ibuf_bank_num * ibuf_bank_size;
    localparam int ibuf_bank_width = 2;
    localparam int bank_idx_width  = $clog2(ibuf_bank_num);

    // head and tail wrap over the whole buffer, the count needs one bit more
    localparam int ibuf_ptr_width = $clog2(ibuf_size);
    localparam int ibuf_cnt_width = ibuf_ptr_width + 1;
    localparam int out_num_width  = $clog2(fetch_width) + 1;

    localparam int fsq_idx_width = 4;

    // one buffered instruction with the tags decode needs to find it again
    typedef struct packed {
        logic                      iam;      // misaligned fetch address
        logic [fsq_idx_width-1:0]  fsq_idx;
        logic [slot_idx_width-1:0] offset;   // slot within the original block
        logic [inst_width-1:0]     inst;
    } ibuf_entry_t;

endpackage

/* inst_buffer.sv */
`timescale 1ns/1ps

module inst_buffer import ibuf_pkg::*; (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       redirect,
    input  logic                                       stall,
    input  logic [block_inst_size-1:0]                 pd_en,
    input  logic [block_num_width-1:0]                 pd_num,
    input  logic [slot_idx_width-1:0]                  pd_shift_idx,
    input  logic [block_inst_size-1:0][inst_width-1:0] pd_inst,
    input  logic [fsq_idx_width-1:0]                   pd_fsq_idx,
    input  logic                                       pd_iam,
    output logic                                       full,
    output logic [fetch_width-1:0]                     out_en,
    output logic [fetch_width-1:0][inst_width-1:0]     out_inst,
    output logic [fetch_width-1:0][fsq_idx_width-1:0]  out_fsq_idx,
    output logic [fetch_width-1:0][slot_idx_width-1:0] out_offset,
    output logic [fetch_width-1:0]                     out_iam
);

    logic [ibuf_ptr_width-1:0]  head;
    logic [ibuf_ptr_width-1:0]  tail;
    logic [ibuf_cnt_width-1:0]  count;
    logic [ibuf_cnt_width-1:0]  fill_level;
    logic [ibuf_bank_width-1:0] rindex [ibuf_bank_num];
    logic [ibuf_bank_width-1:0] windex [ibuf_bank_num];
    ibuf_entry_t                bank_din [ibuf_bank_num];
    ibuf_entry_t                bank_dout [ibuf_bank_num];
    logic [2*ibuf_bank_num-1:0] we_shift;
    logic [2*ibuf_bank_num-1:0] re_shift;
    logic [ibuf_bank_num-1:0]   bank_we;
    logic [ibuf_bank_num-1:0]   bank_re;
    logic                       wr_go;
    logic [block_num_width-1:0] wr_num;
    logic [out_num_width-1:0]   out_num;
    logic [out_num_width-1:0]   rd_num;

    assign fill_level = count + ibuf_cnt_width'(pd_num);
    assign full       = fill_level > ibuf_cnt_width'(ibuf_size);
    assign wr_go      = pd_en[0] & ~full;
    assign wr_num     = wr_go ? pd_num : '0;

    // enable mask rotated onto the banks starting at tail, upper half wraps around
    assign we_shift = (2*ibuf_bank_num)'(pd_en) << tail[bank_idx_width-1:0];
    assign bank_we  = (we_shift[ibuf_bank_num-1:0] | we_shift[2*ibuf_bank_num-1:ibuf_bank_num])
                      & {ibuf_bank_num{wr_go}};

    for (genvar i = 0; i < fetch_width; i++) begin : g_out_en
        assign out_en[i] = count > ibuf_cnt_width'(i);
    end

    assign out_num = (count >= ibuf_cnt_width'(fetch_width)) ? out_num_width'(fetch_width)
                                                              : out_num_width'(count);
    assign rd_num  = stall ? '0 : out_num;

    assign re_shift = (2*ibuf_bank_num)'(out_en) << head[bank_idx_width-1:0];
    assign bank_re  = (re_shift[ibuf_bank_num-1:0] | re_shift[2*ibuf_bank_num-1:ibuf_bank_num])
                      & {ibuf_bank_num{~stall}};

    for (genvar b = 0; b < ibuf_bank_num; b++) begin : g_bank
        logic [bank_idx_width-1:0] wsel;

        assign wsel = bank_idx_width'(b) - tail[bank_idx_width-1:0];  // aligned slot for this bank
        assign bank_din[b] = '{
            iam:     pd_iam,
            fsq_idx: pd_fsq_idx,
            offset:  wsel + pd_shift_idx,
            inst:    pd_inst[wsel]
        };

        inst_buffer_bank u_bank (
            .clk   (clk),
            .rst   (rst),
            .we    (bank_we[b]),
            .waddr (windex[b]),
            .raddr (rindex[b]),
            .din   (bank_din[b]),
            .dout  (bank_dout[b])
        );
    end

    for (genvar i = 0; i < fetch_width; i++) begin : g_read
        logic [bank_idx_width-1:0] rsel;

        assign rsel           = head[bank_idx_width-1:0] + bank_idx_width'(i);
        assign out_inst[i]    = bank_dout[rsel].inst;
        assign out_fsq_idx[i] = bank_dout[rsel].fsq_idx;
        assign out_offset[i]  = bank_dout[rsel].offset;
        assign out_iam[i]     = bank_dout[rsel].iam;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int b = 0; b < ibuf_bank_num; b++) begin
                rindex[b] <= '0;
                windex[b] <= '0;
            end
        end else if (redirect) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int b = 0; b < ibuf_bank_num; b++) begin
                rindex[b] <= '0;
                windex[b] <= '0;
            end
        end else begin
            count <= count + ibuf_cnt_width'(wr_num) - ibuf_cnt_width'(rd_num);
            if (!stall) begin
                head <= head + ibuf_ptr_width'(rd_num);
                for (int b = 0; b < ibuf_bank_num; b++) begin
                    rindex[b] <= rindex[b] + ibuf_bank_width'(bank_re[b]);
                end
            end
            if (wr_go) begin
                tail <= tail + ibuf_ptr_width'(pd_num);
                for (int b = 0; b < ibuf_bank_num; b++) begin
                    windex[b] <= windex[b] + ibuf_bank_width'(bank_we[b]);
                end
            end
        end
    end

endmodule

/* inst_buffer_bank.sv */
`timescale 1ns/1ps

module inst_buffer_bank import ibuf_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we,
    input  logic [ibuf_bank_width-1:0] waddr,
    input  logic [ibuf_bank_width-1:0] raddr,
    input  ibuf_entry_t                din,
    output ibuf_entry_t                dout
);

    ibuf_entry_t ram [ibuf_bank_size];

    assign dout = ram[raddr];  // read is combinational so a write is visible right after the edge

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ibuf_bank_size; i++) begin
                ram[i] <= '0;
            end
        end else if (we) begin
            ram[waddr] <= din;
        end
    end

endmodule

/* predecode.sv */
`timescale 1ns/1ps

module predecode import ibuf_pkg::*; (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      redirect,
    input  logic                                      fetch_valid,
    input  logic [block_inst_size-1:0][inst_width-1:0] fetch_inst,
    input  logic [slot_idx_width-1:0]                 fetch_start,
    input  logic [block_num_width-1:0]                fetch_num,
    input  logic [fsq_idx_width-1:0]                  fetch_fsq_idx,
    input  logic                                      fetch_iam,
    input  logic                                      full,
    output logic                                      fetch_ready,
    output logic [block_inst_size-1:0]                pd_en,
    output logic [block_num_width-1:0]                pd_num,
    output logic [slot_idx_width-1:0]                 pd_shift_idx,
    output logic [block_inst_size-1:0][inst_width-1:0] pd_inst,
    output logic [fsq_idx_width-1:0]                  pd_fsq_idx,
    output logic                                      pd_iam
);

    logic [block_inst_size-1:0][inst_width-1:0] rot_inst;
    logic [block_inst_size-1:0]                 num_mask;
    logic                                       hold;
    logic                                       load;

    // the registered block stays put while the buffer has no room for it
    assign hold        = pd_en[0] & full;
    assign fetch_ready = ~hold;
    assign load        = fetch_valid & fetch_ready;  // a block offered with redirect is dropped

    for (genvar j = 0; j < block_inst_size; j++) begin : g_align
        // rotate left by the start slot so the first valid word lands in slot zero
        assign rot_inst[j] = fetch_inst[fetch_start + slot_idx_width'(j)];
        assign num_mask[j] = fetch_num > block_num_width'(j);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pd_en  <= '0;
            pd_num <= '0;
        end else if (redirect) begin
            pd_en  <= '0;
            pd_num <= '0;
        end else if (load) begin
            pd_en  <= num_mask;
            pd_num <= fetch_num;
        end else if (!hold) begin
            // the held block went into the buffer this edge and nothing replaces it
            pd_en  <= '0;
            pd_num <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pd_inst      <= rot_inst;
            pd_shift_idx <= fetch_start;
            pd_fsq_idx   <= fetch_fsq_idx;
            pd_iam       <= fetch_iam;
        end
    end

endmodule

/* tb_frontend.sv */
`timescale 1ns/1ps

module tb_frontend import ibuf_pkg::*; ();

    localparam int n_rand_blocks   = 200;
    localparam int n_stall_blocks  = 150;
    localparam int n_fill_blocks   = 6;
    localparam int n_pre_redirect  = 10;
    localparam int n_post_redirect = 20;
    localparam int total_blocks    = 1 + n_rand_blocks + n_stall_blocks + n_fill_blocks
                                     + n_pre_redirect + 1 + n_post_redirect;
    localparam int watchdog_cycles = total_blocks * 40;

    typedef ibuf_entry_t entry_q_t[$];

    logic                                       clk;
    logic                                       rst;
    logic                                       redirect;
    logic                                       stall;
    logic                                       fetch_valid;
    logic [block_inst_size-1:0][inst_width-1:0] fetch_inst;
    logic [slot_idx_width-1:0]                  fetch_start;
    logic [block_num_width-1:0]                 fetch_num;
    logic [fsq_idx_width-1:0]                   fetch_fsq_idx;
    logic                                       fetch_iam;
    logic                                       fetch_ready;
    logic                                       full;
    logic [fetch_width-1:0]                     out_en;
    logic [fetch_width-1:0][inst_width-1:0]     out_inst;
    logic [fetch_width-1:0][fsq_idx_width-1:0]  out_fsq_idx;
    logic [fetch_width-1:0][slot_idx_width-1:0] out_offset;
    logic [fetch_width-1:0]                     out_iam;

    entry_q_t buf_q;  // entries the buffer should hold, oldest first
    entry_q_t pd_q;   // the block sitting in predecode, empty when it holds nothing
    int       pass_cnt;
    int       err_cnt;
    logic     random_stall;

    frontend_ibuf_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .redirect      (redirect),
        .stall         (stall),
        .fetch_valid   (fetch_valid),
        .fetch_inst    (fetch_inst),
        .fetch_start   (fetch_start),
        .fetch_num     (fetch_num),
        .fetch_fsq_idx (fetch_fsq_idx),
        .fetch_iam     (fetch_iam),
        .fetch_ready   (fetch_ready),
        .full          (full),
        .out_en        (out_en),
        .out_inst      (out_inst),
        .out_fsq_idx   (out_fsq_idx),
        .out_offset    (out_offset),
        .out_iam       (out_iam)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // valid slots of a block in fetch order, each tagged with its slot in the block
    function automatic entry_q_t expand_block(
        input logic [block_inst_size-1:0][inst_width-1:0] words,
        input logic [slot_idx_width-1:0]                  start,
        input logic [block_num_width-1:0]                 num,
        input logic [fsq_idx_width-1:0]                   fsq,
        input logic                                       iam
    );
        entry_q_t    ents;
        ibuf_entry_t e;
        for (int p = 0; p < int'(num); p++) begin
            e.iam     = iam;
            e.fsq_idx = fsq;
            e.offset  = slot_idx_width'(int'(start) + p);
            e.inst    = words[int'(start) + p];
            ents.push_back(e);
        end
        return ents;
    endfunction

    function automatic logic [fetch_width-1:0] thermo_mask(input int n);
        return fetch_width'((1 << n) - 1);
    endfunction

    task automatic check_entry(input int slot, input ibuf_entry_t got, input ibuf_entry_t exp);
        logic ok;
        ok = 1'b1;
        if (got.inst !== exp.inst) begin
            $display("[ERROR] out_inst[%0d] got %h expected %h", slot, got.inst, exp.inst);
            ok = 1'b0;
        end
        if (got.offset !== exp.offset) begin
            $display("[ERROR] out_offset[%0d] got %h expected %h", slot, got.offset, exp.offset);
            ok = 1'b0;
        end
        if (got.fsq_idx !== exp.fsq_idx) begin
            $display("[ERROR] out_fsq_idx[%0d] got %h expected %h", slot, got.fsq_idx,
                     exp.fsq_idx);
            ok = 1'b0;
        end
        if (got.iam !== exp.iam) begin
            $display("[ERROR] out_iam[%0d] got %h expected %h", slot, got.iam, exp.iam);
            ok = 1'b0;
        end
        if (ok) pass_cnt++;
        else err_cnt++;
    endtask

    task automatic check_count(input logic [fetch_width-1:0] got,
                               input logic [fetch_width-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] out_en got %h expected %h", got, exp);
            err_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            err_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    // every edge compares the pre-edge outputs with the model, then steps the model
    always @(posedge clk) begin : compare_outputs
        ibuf_entry_t got;
        logic        exp_full;
        logic        exp_ready;
        int          consumed;
        int          avail;
        if (rst) begin
            buf_q.delete();
            pd_q.delete();
        end else begin
            avail     = (buf_q.size() < fetch_width) ? buf_q.size() : fetch_width;
            exp_full  = (buf_q.size() + pd_q.size()) > ibuf_size;
            exp_ready = !((pd_q.size() != 0) && exp_full);
            check_count(out_en, thermo_mask(avail));
            check_flag("full", full, exp_full);
            check_flag("fetch_ready", fetch_ready, exp_ready);
            consumed = 0;
            for (int i = 0; i < fetch_width; i++) begin
                if (out_en[i]) begin
                    if (i >= buf_q.size()) begin
                        $display("decode slot %0d was offered while the model queue was empty", i);
                        err_cnt++;
                    end else begin
                        got.inst    = out_inst[i];
                        got.offset  = out_offset[i];
                        got.fsq_idx = out_fsq_idx[i];
                        got.iam     = out_iam[i];
                        check_entry(i, got, buf_q[i]);
                        consumed++;
                    end
                end
            end
            if (redirect) begin
                buf_q.delete();
                pd_q.delete();
            end else begin
                if (!stall) begin
                    repeat (consumed) void'(buf_q.pop_front());
                end
                if ((pd_q.size() != 0) && !exp_full) begin
                    foreach (pd_q[k]) buf_q.push_back(pd_q[k]);
                    pd_q.delete();
                end
                if (fetch_valid && exp_ready) begin
                    pd_q = expand_block(fetch_inst, fetch_start, fetch_num, fetch_fsq_idx,
                                        fetch_iam);
                end
            end
        end
    end

    task automatic update_stall();
        if (random_stall) stall = 1'($urandom_range(1, 0));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
        update_stall();
    endtask

    // offers one block from a falling edge and returns on the falling edge after it is taken
    task automatic send_block(
        input logic [block_inst_size-1:0][inst_width-1:0] words,
        input logic [slot_idx_width-1:0]                  start,
        input logic [block_num_width-1:0]                 num,
        input logic [fsq_idx_width-1:0]                   fsq,
        input logic                                       iam
    );
        logic took;
        fetch_valid   = 1'b1;
        fetch_inst    = words;
        fetch_start   = start;
        fetch_num     = num;
        fetch_fsq_idx = fsq;
        fetch_iam     = iam;
        took          = 1'b0;
        while (!took) begin
            @(posedge clk);
            took = fetch_ready & ~redirect;
            @(negedge clk);
            update_stall();
        end
        fetch_valid = 1'b0;
    endtask

    task automatic send_random_block(input logic [slot_idx_width-1:0] start_limit);
        logic [block_inst_size-1:0][inst_width-1:0] words;
        logic [slot_idx_width-1:0]                  start;
        logic [block_num_width-1:0]                 num;
        for (int j = 0; j < block_inst_size; j++) words[j] = $urandom;
        start = slot_idx_width'($urandom_range(int'(start_limit), 0));
        num   = block_num_width'($urandom_range(block_inst_size - int'(start), 1));
        send_block(words, start, num, fsq_idx_width'($urandom_range(15, 0)),
                   1'($urandom_range(1, 0)));
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((buf_q.size() != 0 || pd_q.size() != 0) && n < limit) begin
            next_cycle();
            n++;
        end
        if (buf_q.size() != 0 || pd_q.size() != 0) begin
            $display("drain did not finish, %0d entries still expected", buf_q.size() + pd_q.size());
            err_cnt++;
        end
        next_cycle();  // one more edge to see out_en fall back to zero
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) $display("%s: pass", name);
        else $display("%s: fail with %0d errors", name, err_cnt - errs_before);
    endtask

    initial begin
        repeat (watchdog_cycles + 16) @(posedge clk);
        $display("watchdog expired after %0d cycles, the stimulus did not complete",
                 watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [block_inst_size-1:0][inst_width-1:0] words;
        int                                         errs;
        void'($urandom(30192));
        rst           = 1'b1;
        redirect      = 1'b0;
        stall         = 1'b0;
        fetch_valid   = 1'b0;
        fetch_inst    = '0;
        fetch_start   = '0;
        fetch_num     = '0;
        fetch_fsq_idx = '0;
        fetch_iam     = 1'b0;
        random_stall  = 1'b0;
        pass_cnt      = 0;
        err_cnt       = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errs = err_cnt;
        for (int j = 0; j < block_inst_size; j++) words[j] = 32'h1000_0000 + j;
        send_block(words, 3'd0, 4'd8, 4'h3, 1'b0);
        wait_drain(40);
        report_test("test 1 single full block", errs);

        errs = err_cnt;
        repeat (n_rand_blocks) send_random_block(3'd7);
        wait_drain(200);
        report_test("test 2 random blocks without stall", errs);

        errs = err_cnt;
        random_stall = 1'b1;
        repeat (n_stall_blocks) send_random_block(3'd7);
        wait_drain(400);
        random_stall = 1'b0;
        stall        = 1'b0;
        if (buf_q.size() != 0 || pd_q.size() != 0) begin
            $display("model queue still holds entries after the stalled run");
            err_cnt++;
        end
        report_test("test 3 random stall and back-pressure", errs);

        errs = err_cnt;
        stall = 1'b1;
        // four full blocks fill the buffer and the fifth waits in predecode
        repeat (n_fill_blocks - 1) begin
            for (int j = 0; j < block_inst_size; j++) words[j] = $urandom;
            send_block(words, 3'd0, 4'd8, fsq_idx_width'($urandom_range(15, 0)),
                       1'($urandom_range(1, 0)));
        end
        for (int j = 0; j < block_inst_size; j++) words[j] = 32'hf111_0000 + j;
        fetch_valid   = 1'b1;
        fetch_inst    = words;
        fetch_start   = 3'd0;
        fetch_num     = 4'd8;
        fetch_fsq_idx = 4'ha;
        fetch_iam     = 1'b1;
        repeat (4) begin
            @(posedge clk);
            check_flag("fetch_ready", fetch_ready, 1'b0);
            check_flag("full", full, 1'b1);
            check_count(out_en, 4'hf);
            @(negedge clk);
        end
        if (buf_q.size() != ibuf_size) begin
            $display("buffer filled to %0d entries instead of %0d", buf_q.size(), ibuf_size);
            err_cnt++;
        end
        stall = 1'b0;
        send_block(words, 3'd0, 4'd8, 4'ha, 1'b1);
        wait_drain(100);
        report_test("test 4 fill to capacity and drain", errs);

        errs = err_cnt;
        repeat (n_pre_redirect / 2) send_random_block(3'd7);
        stall = 1'b1;
        repeat (n_pre_redirect / 2) send_random_block(3'd7);
        redirect    = 1'b1;  // the block offered alongside the redirect is dropped
        fetch_valid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        redirect    = 1'b0;
        fetch_valid = 1'b0;
        stall       = 1'b0;
        @(posedge clk);
        check_count(out_en, '0);
        check_flag("full", full, 1'b0);
        @(negedge clk);
        repeat (n_post_redirect) send_random_block(3'd7);
        wait_drain(100);
        report_test("test 5 redirect in mid-traffic", errs);

        $display("checks passed %0d, errors %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
ibuf_pkg.sv
inst_buffer_bank.sv
predecode.sv
inst_buffer.sv
frontend_ibuf_top.sv
tb_frontend.sv
